// ==== bench/gpio_stimulus.txt ====
# op idx data pins stall exp_data exp_err, all hex, one step per line
# op: 0 read, 1 write, 2 drive pins for data cycles, 3 check gpio_data, 4 read latency, f end of test
# test 1, output data and its AND, OR and XOR forms
1 00 00a5a5a5 000000 0 00000000 0
0 00 00000000 000000 0 00a5a5a5 0
1 01 00ff00ff 000000 0 00000000 0
0 00 00000000 000000 0 00a500a5 0
1 02 00000f00 000000 0 00000000 0
0 01 00000000 000000 0 00a50fa5 0
1 03 00ffffff 000000 0 00000000 0
0 03 00000000 000000 0 005af05a 0
1 00 12345678 000000 0 00000000 0
0 00 00000000 000000 0 00345678 0
f 00 00000001 000000 0 00000000 0
# test 2, output enables and error responses
1 04 00f0f00f 000000 0 00000000 0
0 04 00000000 000000 0 00f0f00f 0
0 09 00000000 000000 0 00000000 1
0 3f 00000000 000000 0 00000000 1
1 05 00ffffff 000000 0 00000000 1
1 0a 0000ffff 000000 0 00000000 1
0 04 00000000 000000 0 00f0f00f 0
0 05 00000000 000000 0 00000000 0
f 00 00000002 000000 0 00000000 0
# test 3, input data read back
2 00 0000000a c3a55a 0 00000000 0
0 05 00000000 000000 0 00c3a55a 0
2 00 0000000a 000001 0 00000000 0
0 05 00000000 000000 0 00000001 0
f 00 00000003 000000 0 00000000 0
# test 4, edge status, mask, polarity and clear
0 08 00000000 000000 0 00c3a55b 0
1 08 00ffffff 000000 0 00000000 0
0 08 00000000 000000 0 00000000 0
1 07 000000f0 000000 0 00000000 0
1 06 0000003c 000000 0 00000000 0
0 07 00000000 000000 0 000000f0 0
3 00 00000000 000000 0 00000000 0
2 00 0000000a 0000f1 0 00000000 0
3 00 00000000 000000 0 00000030 0
0 08 00000000 000000 0 000000f0 0
2 00 0000000a 0000fd 0 00000000 0
0 08 00000000 000000 0 000000f0 0
2 00 0000000a 0000f0 0 00000000 0
0 08 00000000 000000 0 000000fd 0
3 00 00000000 000000 0 0000003c 0
1 08 00000034 000000 0 00000000 0
3 00 00000000 000000 0 00000008 0
0 08 00000000 000000 0 000000c9 0
1 08 000000ff 000000 0 00000000 0
3 00 00000000 000000 0 00000000 0
f 00 00000004 000000 0 00000000 0
# test 5, random response back-pressure
1 00 00111111 000000 1 00000000 0
0 00 00000000 000000 1 00111111 0
1 02 00222222 000000 1 00000000 0
0 02 00000000 000000 1 00333333 0
1 03 00030303 000000 1 00000000 0
0 00 00000000 000000 1 00303030 0
1 04 00ffffff 000000 1 00000000 0
0 04 00000000 000000 1 00ffffff 0
0 06 00000000 000000 1 0000003c 0
0 07 00000000 000000 1 000000f0 0
0 05 00000000 000000 1 000000f0 0
0 0c 00000000 000000 1 00000000 1
1 05 00000001 000000 1 00000000 1
1 01 000f0f0f 000000 1 00000000 0
0 00 00000000 000000 1 00000000 0
0 08 00000000 000000 1 00000000 0
f 00 00000005 000000 1 00000000 0
# test 6, read latency without stalls
4 06 00000000 000000 0 0000003c 0
4 05 00000000 000000 0 000000f0 0
f 00 00000006 000000 0 00000000 0

// ==== bench/gpio_tb.sv ====
/*
 * GPIO testbench
 * Replays the stimulus file on gpio_top, checks responses, pins and interrupts
 */
`timescale 1ns/1ps
`include "gpio_settings.svh"

module gpio_tb
   import gpio_pkg::*;
();

   // One line of the stimulus file
   typedef struct {
      logic [3:0] op;        // 0 read, 1 write, 2 pins, 3 irq, 4 latency, f end of test
      reg_idx_t   idx;
      reg_data_t  data;      // Write data, cycle count or test number
      pin_vec_t   pins;
      logic       stall;     // Random rsp_ready back-pressure
      reg_data_t  exp_data;
      logic       exp_err;
   } step_t;

   // Response still owed by the DUT
   typedef struct {
      logic      write;
      reg_idx_t  idx;
      reg_data_t rdata;
      logic      err;
      pin_vec_t  out;        // io_out once this request is done
      pin_vec_t  en;
   } exp_t;

   logic      clk;
   logic      arst_n;
   logic      req_valid;
   logic      req_ready;
   gpio_req_t req;
   logic      rsp_valid;
   logic      rsp_ready;
   gpio_rsp_t rsp;
   pin_vec_t  io_in;
   pin_vec_t  io_out;
   pin_vec_t  io_en;
   logic      gpio_irq;
   pin_vec_t  gpio_data;

   step_t       steps[$];
   exp_t        exp_q[$];        // In request order
   pin_vec_t    model_out;       // Output data from writes sent so far
   pin_vec_t    model_en;
   logic        stall_mode;
   int          errors = 0;
   int          test_errors = 0; // Error count when the test began
   int          tests_pass = 0;
   int          tests_fail = 0;
   int          n_sent = 0;
   int          n_rcvd = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   gpio_top i_dut (
      .clk, .arst_n,
      .req_valid, .req_ready, .req,
      .rsp_valid, .rsp_ready, .rsp,
      .io_in, .io_out, .io_en,
      .gpio_irq, .gpio_data
   );

   // ####################
   // Clock, stalls, timeout
   // ####################
   always #50 clk = ~clk;     // 100 ns period

   always @(posedge clk) begin
      #1;
      if (stall_mode)
         rsp_ready = ($urandom % 3) != 0;   // Stall about one cycle in three
      else
         rsp_ready = 1'b1;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit != 0 && cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Handshake seen mid-cycle and taken at the next rising edge
   always @(negedge clk) begin
      if (arst_n && rsp_valid && rsp_ready)
         match_response();
   end

   // ####################
   // Reference model
   // ####################
   function automatic void update_model(input reg_idx_t idx, input pin_vec_t wd);
      case (int'(idx))
         `GPIO_ODATA:    model_out = wd;
         `GPIO_ODATAAND: model_out = model_out & wd;
         `GPIO_ODATAORR: model_out = model_out | wd;
         `GPIO_ODATAXOR: model_out = model_out ^ wd;
         `GPIO_OEN:      model_en  = wd;
         default: ;                          // No pin effect
      endcase
   endfunction

   task automatic match_response();
      exp_t e;
      n_rcvd++;                              // Every response the host takes
      if (exp_q.size() == 0) begin
         $display("error at %0t ns: response arrived with no request pending", $time);
         errors++;
      end else begin
         e = exp_q.pop_front();
         if (rsp.rdata !== e.rdata || rsp.err !== e.err) begin
            $display("mismatch at %0t ns: idx %h gave data %h err %b, expected %h err %b",
                     $time, e.idx, rsp.rdata, rsp.err, e.rdata, e.err);
            errors++;
         end
         if (e.write && (io_out !== e.out || io_en !== e.en)) begin
            $display("mismatch at %0t ns: write idx %h left io_out %h io_en %h, expected %h %h",
                     $time, e.idx, io_out, io_en, e.out, e.en);
            errors++;
         end
      end
   endtask

   // ####################
   // Stimulus tasks
   // ####################
   task automatic load_steps(input int fd);
      string       line;
      step_t       st;
      logic [31:0] f_op, f_idx, f_data, f_pins, f_stall, f_exp, f_err;
      int          n;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%h %h %h %h %h %h %h",
                     f_op, f_idx, f_data, f_pins, f_stall, f_exp, f_err);
         if (n == 7) begin                   // Comment and blank lines fall out here
            st.op       = f_op[3:0];
            st.idx      = f_idx[`GPIO_AW-1:0];
            st.data     = f_data;
            st.pins     = f_pins[`GPIO_N-1:0];
            st.stall    = f_stall[0];
            st.exp_data = f_exp;
            st.exp_err  = f_err[0];
            steps.push_back(st);
         end
      end
      $fclose(fd);
   endtask

   // Returns one ns after the edge that took the request
   task automatic send_req(input logic wr, input reg_idx_t idx, input reg_data_t data,
                           input reg_data_t exp_data, input logic exp_err);
      exp_t e;
      if (wr)
         update_model(idx, data[`GPIO_N-1:0]);
      e.write = wr;
      e.idx   = idx;
      e.rdata = wr ? '0 : exp_data;          // Writes answer with zero
      e.err   = exp_err;
      e.out   = model_out;
      e.en    = model_en;
      exp_q.push_back(e);
      req_valid = 1'b1;
      req.write = wr;
      req.idx   = idx;
      req.data  = data;
      @(negedge clk);
      while (!req_ready)
         @(negedge clk);
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      n_sent++;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic drive_pins(input pin_vec_t pins, input int hold);
      io_in = pins;
      repeat (hold) @(posedge clk);
      #1;
   endtask

   task automatic check_irq(input pin_vec_t exp_v);
      wait_idle();
      @(negedge clk);
      if (gpio_data !== exp_v || gpio_irq !== (|exp_v)) begin
         $display("mismatch at %0t ns: gpio_data %h irq %b, expected %h irq %b",
                  $time, gpio_data, gpio_irq, exp_v, |exp_v);
         errors++;
      end
      @(posedge clk);
      #1;
   endtask

   // Counts edges from request acceptance to rsp_valid
   task automatic measure_latency(input reg_idx_t idx, input reg_data_t exp_v);
      int lat;
      stall_mode = 1'b0;
      wait_idle();
      send_req(1'b0, idx, '0, exp_v, 1'b0);
      @(negedge clk);
      lat = 0;
      while (!rsp_valid && lat < 8) begin
         @(negedge clk);
         lat++;
      end
      if (lat != 2) begin
         $display("mismatch at %0t ns: read idx %h took %0d edges, expected 2",
                  $time, idx, lat);
         errors++;
      end
      wait_idle();
   endtask

   task automatic close_test(input int num);
      wait_idle();
      if (errors == test_errors) begin
         $display("test %0d: pass", num);
         tests_pass++;
      end else begin
         $display("test %0d: fail, %0d errors", num, errors - test_errors);
         tests_fail++;
      end
      test_errors = errors;
   endtask

   task automatic run_step(input step_t st);
      case (st.op)
         4'h0: begin
            stall_mode = st.stall;
            send_req(1'b0, st.idx, '0, st.exp_data, st.exp_err);
         end
         4'h1: begin
            stall_mode = st.stall;
            send_req(1'b1, st.idx, st.data, '0, st.exp_err);
         end
         4'h2: drive_pins(st.pins, int'(st.data));
         4'h3: check_irq(st.exp_data[`GPIO_N-1:0]);
         4'h4: measure_latency(st.idx, st.exp_data);
         4'hf: close_test(int'(st.data));
         default: begin
            $display("error: unknown stimulus operation %h", st.op);
            errors++;
         end
      endcase
   endtask

   // ####################
   // Main sequence
   // ####################
   initial begin
      int fd;
      clk        = 1'b0;
      arst_n     = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      rsp_ready  = 1'b1;
      io_in      = '0;
      stall_mode = 1'b0;
      model_out  = `GPIO_ODATA_RST;
      model_en   = `GPIO_OEN_RST;
      void'($urandom(32'h2267e74a));
      fd = $fopen("bench/gpio_stimulus.txt", "r");
      if (fd == 0) begin
         $display("error: cannot open bench/gpio_stimulus.txt");
         $display("TEST FAILED");
         $finish;
      end else begin
         load_steps(fd);
         cycle_limit = 200 * steps.size();
         repeat (8) @(posedge clk);          // Reset held for 8 cycles
         #1;
         arst_n = 1'b1;
         foreach (steps[i])
            run_step(steps[i]);
         wait_idle();
         if (n_sent != n_rcvd) begin
            $display("error: %0d requests sent but %0d responses received", n_sent, n_rcvd);
            errors++;
         end
         $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
         if (errors == 0)
            $display("TEST OK");
         else
            $display("TEST FAILED");
         $finish;
      end
   end

endmodule

// ==== gpio_top.f ====
+incdir+source
source/gpio_pkg.sv
source/gpio_req_decode.sv
source/gpio_reg_exec.sv
source/gpio_input_sync.sv
source/gpio_irq_status.sv
source/gpio_rsp_stage.sv
source/gpio_top.sv
bench/gpio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f gpio_top.f --top-module gpio_tb
./obj_dir/Vgpio_tb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "TEST OK" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"

// ==== source/gpio_input_sync.sv ====
/*
 * GPIO input synchronizer
 * Two-flop synchronizer, input data register and per-pin edge detect
 */
`timescale 1ns/1ps

module gpio_input_sync
   import gpio_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  pin_vec_t io_in,   // Asynchronous pin inputs
   output pin_vec_t idata,   // Synchronized input data
   output pin_vec_t rise,    // One-cycle pulse on 0 to 1
   output pin_vec_t fall     // One-cycle pulse on 1 to 0
);

   pin_vec_t sync_q1;   // First stage, may go metastable
   pin_vec_t sync_q2;   // Second stage, settled
   pin_vec_t idata_q;   // IDATA one cycle back

   // ####################
   // Synchronizer
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= io_in;
         sync_q2 <= sync_q1;
      end
   end

   // ####################
   // Input data and history
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         idata   <= '0;
         idata_q <= '0;
      end else begin
         idata   <= sync_q2;   // Three edges after the pin
         idata_q <= idata;
      end
   end

   // Edge compare against the previous value
   assign rise = idata & ~idata_q;
   assign fall = ~idata & idata_q;

endmodule

// ==== source/gpio_irq_status.sv ====
/*
 * GPIO interrupt status
 * Sticky per-pin edge events, write-one-to-clear, masked interrupt outputs
 */
`timescale 1ns/1ps

module gpio_irq_status
   import gpio_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  pin_vec_t rise,        // Rising edge pulses
   input  pin_vec_t fall,        // Falling edge pulses
   input  pin_vec_t ipol,        // 1 rising, 0 falling
   input  pin_vec_t imask,       // 1 lets the pin interrupt
   input  pin_vec_t status_clr,  // Bits written to ISTATUS
   output pin_vec_t istatus,     // Sticky status
   output logic     gpio_irq,    // Combined interrupt
   output pin_vec_t gpio_data    // Per-pin interrupts
);

   pin_vec_t event_hit;   // Edge in the selected direction

   // ####################
   // Event select
   // ####################
   assign event_hit = (rise & ipol) | (fall & ~ipol);

   // ####################
   // Sticky status
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         istatus <= '0;
      end else begin
         // A new event beats a clear in the same cycle
         istatus <= (istatus & ~status_clr) | event_hit;
      end
   end

   // ####################
   // Interrupt outputs
   // ####################
   // Logic only, no extra flop after status
   assign gpio_data = istatus & imask;
   assign gpio_irq  = |gpio_data;

endmodule

// ==== source/gpio_pkg.sv ====
/*
 * GPIO types
 * Vector typedefs, register names and the structs passed along the pipeline
 */
`include "gpio_settings.svh"

package gpio_pkg;

   typedef logic [`GPIO_N-1:0]  pin_vec_t;   // One bit per pin
   typedef logic [`GPIO_DW-1:0] reg_data_t;  // Register word
   typedef logic [`GPIO_AW-1:0] reg_idx_t;   // Register word index

   // Register names on the index
   typedef enum reg_idx_t {
      IDX_ODATA    = `GPIO_ODATA,
      IDX_ODATAAND = `GPIO_ODATAAND,
      IDX_ODATAORR = `GPIO_ODATAORR,
      IDX_ODATAXOR = `GPIO_ODATAXOR,
      IDX_OEN      = `GPIO_OEN,
      IDX_IDATA    = `GPIO_IDATA,
      IDX_IMASK    = `GPIO_IMASK,
      IDX_IPOL     = `GPIO_IPOL,
      IDX_ISTATUS  = `GPIO_ISTATUS
   } reg_name_e;

   // Host request, 39 bits
   typedef struct packed {
      logic      write;   // 1 write, 0 read
      reg_idx_t  idx;
      reg_data_t data;    // Write data
   } gpio_req_t;

   // One-hot register selection
   typedef struct packed {
      logic unknown;      // No register at this index
      logic istatus;
      logic ipol;
      logic imask;
      logic idata;
      logic oen;
      logic odataxor;
      logic odataorr;
      logic odataand;
      logic odata;
   } reg_sel_t;

   // Decode to execute
   typedef struct packed {
      logic      write;
      reg_sel_t  sel;
      reg_data_t data;
   } gpio_dec_t;

   // Response to host
   typedef struct packed {
      reg_data_t rdata;   // Zero for writes
      logic      err;     // Unknown index or IDATA write
   } gpio_rsp_t;

endpackage

// ==== source/gpio_reg_exec.sv ====
/*
 * GPIO execute stage
 * Output data, enable, mask and polarity registers; applies writes, samples reads
 */
`timescale 1ns/1ps
`include "gpio_settings.svh"

module gpio_reg_exec
   import gpio_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      dec_valid,
   output logic      dec_ready,
   input  gpio_dec_t dec,
   output logic      exe_valid,
   input  logic      exe_ready,
   output gpio_rsp_t exe_rsp,
   input  pin_vec_t  idata,
   input  pin_vec_t  istatus,
   output pin_vec_t  io_out,
   output pin_vec_t  io_en,
   output pin_vec_t  imask,
   output pin_vec_t  ipol,
   output pin_vec_t  status_clr
);

   gpio_dec_t item;          // Request held in this stage
   logic      exe_go;        // Item leaves for the response stage
   logic      wr_go;         // Held write commits now
   pin_vec_t  wdata;
   pin_vec_t  odata_nxt;
   pin_vec_t  oen_nxt;
   pin_vec_t  imask_nxt;
   pin_vec_t  ipol_nxt;
   pin_vec_t  istatus_view;  // Status as a following read must see it
   gpio_rsp_t rsp_nxt;

   assign dec_ready = ~exe_valid | exe_ready;
   assign exe_go    = exe_valid & exe_ready;
   assign wr_go     = exe_go & item.write;
   assign wdata     = item.data[`GPIO_N-1:0];

   // ####################
   // Write commit
   // ####################
   always_comb begin
      odata_nxt = io_out;
      oen_nxt   = io_en;
      imask_nxt = imask;
      ipol_nxt  = ipol;
      if (wr_go) begin
         if (item.sel.odata)
            odata_nxt = wdata;
         else if (item.sel.odataand)
            odata_nxt = io_out & wdata;
         else if (item.sel.odataorr)
            odata_nxt = io_out | wdata;
         else if (item.sel.odataxor)
            odata_nxt = io_out ^ wdata;
         if (item.sel.oen)
            oen_nxt = wdata;
         if (item.sel.imask)
            imask_nxt = wdata;
         if (item.sel.ipol)
            ipol_nxt = wdata;
      end
   end

   assign status_clr   = (wr_go && item.sel.istatus) ? wdata : '0;  // W1C pulse
   assign istatus_view = istatus & ~status_clr;

   // ####################
   // Read sample
   // ####################
   // Reads look at next-state values so a write just ahead is visible
   always_comb begin
      rsp_nxt = '0;
      if (dec.sel.unknown)
         rsp_nxt.err = 1'b1;
      else if (dec.write)
         rsp_nxt.err = dec.sel.idata;  // IDATA is read only
      else if (dec.sel.oen)
         rsp_nxt.rdata = reg_data_t'(oen_nxt);
      else if (dec.sel.idata)
         rsp_nxt.rdata = reg_data_t'(idata);
      else if (dec.sel.imask)
         rsp_nxt.rdata = reg_data_t'(imask_nxt);
      else if (dec.sel.ipol)
         rsp_nxt.rdata = reg_data_t'(ipol_nxt);
      else if (dec.sel.istatus)
         rsp_nxt.rdata = reg_data_t'(istatus_view);
      else
         rsp_nxt.rdata = reg_data_t'(odata_nxt);  // ODATA and its AND/OR/XOR aliases
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exe_valid <= 1'b0;
         io_out    <= `GPIO_ODATA_RST;
         io_en     <= `GPIO_OEN_RST;
         imask     <= `GPIO_IMASK_RST;
         ipol      <= `GPIO_IPOL_RST;
      end else begin
         if (dec_ready)
            exe_valid <= dec_valid;
         io_out <= odata_nxt;
         io_en  <= oen_nxt;
         imask  <= imask_nxt;
         ipol   <= ipol_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid && dec_ready) begin
         item    <= dec;
         exe_rsp <= rsp_nxt;
      end
   end

   // Decoder hands over exactly one register flag
   a_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid |-> $onehot(dec.sel))
      else $error("Decoded selection not one-hot");

   // Stalled response holds until taken
   a_exe_stable: assert property (@(posedge clk) disable iff (!arst_n)
      exe_valid && !exe_ready |=> exe_valid && $stable(exe_rsp))
      else $error("Execute response changed under back-pressure");

endmodule

// ==== source/gpio_req_decode.sv ====
/*
 * GPIO request decode stage
 * Takes a host request and registers a one-hot register selection with it
 */
`timescale 1ns/1ps

module gpio_req_decode
   import gpio_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   // Host request
   input  logic      req_valid,
   output logic      req_ready,
   input  gpio_req_t req,
   // Toward execute stage
   output logic      dec_valid,
   input  logic      dec_ready,
   output gpio_dec_t dec
);

   reg_sel_t sel_nxt;   // Selection for the incoming request

   // ####################
   // Index compare
   // ####################
   always_comb begin
      sel_nxt = '0;
      case (req.idx)
         IDX_ODATA:    sel_nxt.odata    = 1'b1;
         IDX_ODATAAND: sel_nxt.odataand = 1'b1;
         IDX_ODATAORR: sel_nxt.odataorr = 1'b1;
         IDX_ODATAXOR: sel_nxt.odataxor = 1'b1;
         IDX_OEN:      sel_nxt.oen      = 1'b1;
         IDX_IDATA:    sel_nxt.idata    = 1'b1;
         IDX_IMASK:    sel_nxt.imask    = 1'b1;
         IDX_IPOL:     sel_nxt.ipol     = 1'b1;
         IDX_ISTATUS:  sel_nxt.istatus  = 1'b1;
         default:      sel_nxt.unknown  = 1'b1;  // Hole in the map
      endcase
   end

   // ####################
   // Output register
   // ####################
   // Empty, or emptied this cycle by the execute stage
   assign req_ready = ~dec_valid | dec_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_valid <= 1'b0;
      end else if (req_ready) begin
         dec_valid <= req_valid;  // Load or drain
      end
   end

   // Payload, only loaded on a transfer
   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         dec <= '{write: req.write, sel: sel_nxt, data: req.data};
      end
   end

endmodule

// ==== source/gpio_rsp_stage.sv ====
/*
 * GPIO response stage
 * Response register with valid/ready toward the host
 */
`timescale 1ns/1ps

module gpio_rsp_stage
   import gpio_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   // From execute stage
   input  logic      exe_valid,
   output logic      exe_ready,
   input  gpio_rsp_t exe_rsp,
   // To host
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output gpio_rsp_t rsp
);

   logic load;   // Execute stage hands over a response

   // ####################
   // Handshake
   // ####################
   // Room when empty or the host takes the current one
   assign exe_ready = ~rsp_valid | rsp_ready;
   assign load      = exe_valid & exe_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid <= 1'b0;
      end else if (exe_ready) begin
         rsp_valid <= exe_valid;  // Refill or go empty
      end
   end

   // ####################
   // Response register
   // ####################
   always_ff @(posedge clk) begin
      if (load) begin
         rsp <= exe_rsp;
      end
   end

   // Host sees the same response until it takes it
   a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else $error("Response changed while stalled");

endmodule

// ==== source/gpio_settings.svh ====
/*
 * GPIO block settings
 * Pin count, register map word indexes, widths and register reset values
 */
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// ####################
// Widths
// ####################
`define GPIO_N  24          // Number of pins
`define GPIO_DW 32          // Register data width
`define GPIO_AW 6           // Word index, address bits 7:2

// ####################
// Register map
// ####################
`define GPIO_ODATA     0    // Output data
`define GPIO_ODATAAND  1    // Output data AND
`define GPIO_ODATAORR  2    // Output data OR
`define GPIO_ODATAXOR  3    // Output data XOR
`define GPIO_OEN       4    // Output enables
`define GPIO_IDATA     5    // Synchronized input data, read only
`define GPIO_IMASK     6    // Interrupt mask
`define GPIO_IPOL      7    // Edge polarity, 1 means rising
`define GPIO_ISTATUS   8    // Sticky edge status, write one to clear

// Reset values
`define GPIO_ODATA_RST {`GPIO_N{1'b0}}
`define GPIO_OEN_RST   {`GPIO_N{1'b0}}
`define GPIO_IMASK_RST {`GPIO_N{1'b0}}
`define GPIO_IPOL_RST  {`GPIO_N{1'b1}}   // All pins watch rising edges

`endif

// ==== source/gpio_top.sv ====
/*
 * GPIO top level
 * Decode, execute and response stages with input sync and interrupt status
 */
`timescale 1ns/1ps

module gpio_top
   import gpio_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   // Register requests
   input  logic      req_valid,
   output logic      req_ready,
   input  gpio_req_t req,
   // Responses
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output gpio_rsp_t rsp,
   // Pins
   input  pin_vec_t  io_in,
   output pin_vec_t  io_out,
   output pin_vec_t  io_en,
   // Interrupts
   output logic      gpio_irq,
   output pin_vec_t  gpio_data
);

   // ####################
   // Stage links
   // ####################
   logic      dec_valid;
   logic      dec_ready;
   gpio_dec_t dec;
   logic      exe_valid;
   logic      exe_ready;
   gpio_rsp_t exe_rsp;

   // Side paths
   pin_vec_t idata;
   pin_vec_t rise;
   pin_vec_t fall;
   pin_vec_t imask;
   pin_vec_t ipol;
   pin_vec_t status_clr;
   pin_vec_t istatus;

   gpio_req_decode i_decode (
      .clk, .arst_n,
      .req_valid, .req_ready, .req,
      .dec_valid, .dec_ready, .dec
   );

   gpio_reg_exec i_exec (
      .clk, .arst_n,
      .dec_valid, .dec_ready, .dec,
      .exe_valid, .exe_ready, .exe_rsp,
      .idata, .istatus,
      .io_out, .io_en, .imask, .ipol, .status_clr
   );

   gpio_rsp_stage i_rsp (
      .clk, .arst_n,
      .exe_valid, .exe_ready, .exe_rsp,
      .rsp_valid, .rsp_ready, .rsp
   );

   gpio_input_sync i_sync (
      .clk, .arst_n,
      .io_in, .idata, .rise, .fall
   );

   gpio_irq_status i_irq (
      .clk, .arst_n,
      .rise, .fall, .ipol, .imask, .status_clr,
      .istatus, .gpio_irq, .gpio_data
   );

endmodule
